// File: hdl/ram_access_pkg.sv
// shared widths, types and MBIST pattern constants for the 128x11 RAM access shell
// every RTL file refers to these by scoped name
package ram_access_pkg;

  // ------------------------------------------------------------
  // array geometry
  // ------------------------------------------------------------
  localparam int ram_depth  = 128;
  localparam int ram_addr_w = 7;
  localparam int ram_data_w = 11;

  // ------------------------------------------------------------
  // MBIST background pattern
  // ------------------------------------------------------------
  localparam int mbist_pat_w = 2;
  // full copies of the pattern in one word, bit 0 fills the odd top bit
  localparam int mbist_pat_rep = ram_data_w / mbist_pat_w;

  // address into the array
  typedef logic [ram_addr_w-1:0] ram_addr_t;

  // one data word
  typedef logic [ram_data_w-1:0] ram_data_t;

  // background pattern from the MBIST controller
  typedef logic [mbist_pat_w-1:0] mbist_pat_t;

  // owner of the array ports
  typedef enum logic {
    src_func  = 1'b0,
    src_mbist = 1'b1
  } port_src_t;

endpackage

// File: hdl/ram_port_mux.sv
// port source selection for the RAM shell: registers the MBIST enable and steers
// functional or MBIST address, data and enables onto the array ports
`timescale 1ns/10ps

module ram_port_mux (
  input  logic                      clk,
  input  logic                      mbist_ramaccess_rst_,
  input  logic                      mbist_en_sync,
  input  logic                      we,
  input  logic                      re,
  input  logic                      write_inh,
  input  logic                      mbist_we_w0,
  input  logic                      mbist_ce_r0,
  input  ram_access_pkg::ram_addr_t wa,
  input  ram_access_pkg::ram_addr_t ra,
  input  ram_access_pkg::ram_addr_t mbist_wa_w0,
  input  ram_access_pkg::ram_addr_t mbist_ra_r0,
  input  ram_access_pkg::ram_data_t di,
  input  ram_access_pkg::mbist_pat_t mbist_di_w0,
  output logic                      arr_we,
  output logic                      arr_re,
  output ram_access_pkg::ram_addr_t arr_wa,
  output ram_access_pkg::ram_addr_t arr_ra,
  output ram_access_pkg::ram_data_t arr_wd,
  output ram_access_pkg::port_src_t port_src
);

  ram_access_pkg::ram_data_t mbist_wd;
  logic                      mbist_sel;
  logic                      pre_we;

  // ------------------------------------------------------------
  // MBIST enable register
  // ------------------------------------------------------------
  // the synchronized enable is flopped once more so the port swap
  // happens on a clean edge
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      port_src <= ram_access_pkg::src_func;
    end else if (mbist_en_sync) begin
      port_src <= ram_access_pkg::src_mbist;
    end else begin
      port_src <= ram_access_pkg::src_func;
    end
  end

  assign mbist_sel = (port_src == ram_access_pkg::src_mbist);

  // ------------------------------------------------------------
  // background pattern expansion
  // ------------------------------------------------------------
  // 2'b01 -> 11'h555, 2'b10 -> 11'h2aa
  assign mbist_wd = {mbist_di_w0[0], {ram_access_pkg::mbist_pat_rep{mbist_di_w0}}};

  // ------------------------------------------------------------
  // source muxes
  // ------------------------------------------------------------
  always_comb begin
    if (mbist_sel) begin
      pre_we = mbist_we_w0;
      arr_re = mbist_ce_r0;
      arr_wa = mbist_wa_w0;
      arr_ra = mbist_ra_r0;
      arr_wd = mbist_wd;
    end else begin
      pre_we = we;
      arr_re = re;
      arr_wa = wa;
      arr_ra = ra;
      arr_wd = di;
    end
  end

  // write inhibit blocks both sources
  assign arr_we = pre_we & ~write_inh;

endmodule

// File: hdl/ram_array_128x11.sv
// 128x11 storage array with one synchronous write port and one registered
// read port; a read and write to the same word at one edge returns old data
`timescale 1ns/10ps

module ram_array_128x11 (
  input  logic                      clk,
  input  logic                      arr_we,
  input  logic                      arr_re,
  input  ram_access_pkg::ram_addr_t arr_wa,
  input  ram_access_pkg::ram_addr_t arr_ra,
  input  ram_access_pkg::ram_data_t arr_wd,
  output ram_access_pkg::ram_data_t arr_rd
);

  ram_access_pkg::ram_data_t mem [ram_access_pkg::ram_depth];

  // ------------------------------------------------------------
  // write port
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (arr_we) begin
      mem[arr_wa] <= arr_wd;
    end
  end

  // ------------------------------------------------------------
  // read port
  // ------------------------------------------------------------
  // samples the stored word before this edge's write lands,
  // and holds until the next read
  always_ff @(posedge clk) begin
    if (arr_re) begin
      arr_rd <= mem[arr_ra];
    end
  end

  // ------------------------------------------------------------
  // checks
  // ------------------------------------------------------------
  // an unknown address would corrupt or read an arbitrary word
  a_wa_known : assert property (
    @(posedge clk) arr_we |-> !$isunknown(arr_wa)
  ) else $error("write address has unknown bits while arr_we is high");

  a_ra_known : assert property (
    @(posedge clk) arr_re |-> !$isunknown(arr_ra)
  ) else $error("read address has unknown bits while arr_re is high");

endmodule

// File: hdl/ram_read_capture.sv
// output side of the RAM shell: array bypass, MBIST chip-enable delay and
// the capture register that feeds dout and mbist_do_r0
`timescale 1ns/10ps

module ram_read_capture (
  input  logic                      clk,
  input  logic                      mbist_ramaccess_rst_,
  input  logic                      ore,
  input  logic                      mbist_ce_r0,
  input  logic                      scan_ramtms,
  input  logic                      ary_read_inh,
  input  ram_access_pkg::port_src_t port_src,
  input  ram_access_pkg::ram_data_t arr_rd,
  input  ram_access_pkg::ram_data_t arr_wd,
  output ram_access_pkg::ram_data_t data_q
);

  logic                      bypass;
  logic                      mbist_ce_dly;
  logic                      cap_en;
  ram_access_pkg::ram_data_t cap_d;

  // ------------------------------------------------------------
  // array bypass
  // ------------------------------------------------------------
  // in test mode or with reads inhibited the write-side data is
  // looped straight to the capture register
  assign bypass = scan_ramtms | ary_read_inh;
  assign cap_d  = bypass ? arr_wd : arr_rd;

  // ------------------------------------------------------------
  // capture enable
  // ------------------------------------------------------------
  // the array read launched by mbist_ce_r0 is ready one edge later
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      mbist_ce_dly <= 1'b0;
    end else begin
      mbist_ce_dly <= mbist_ce_r0;
    end
  end

  // ore only counts on the functional side
  assign cap_en = (port_src == ram_access_pkg::src_mbist) ? mbist_ce_dly : ore;

  // ------------------------------------------------------------
  // capture register
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge mbist_ramaccess_rst_) begin
    if (!mbist_ramaccess_rst_) begin
      data_q <= '0;
    end else if (cap_en) begin
      data_q <= cap_d;
    end
  end

endmodule

// File: hdl/ram_access_top.sv
// top of the 128x11 two-port RAM shell with MBIST access; connects the port
// mux, the array and the output capture stage
`timescale 1ns/10ps

module ram_access_top (
  input  logic                       clk,
  input  logic                       mbist_ramaccess_rst_,
  input  logic                       we,
  input  logic                       re,
  input  logic                       ore,
  input  logic                       write_inh,
  input  logic                       scan_ramtms,
  input  logic                       ary_read_inh,
  input  logic                       mbist_en_sync,
  input  logic                       mbist_we_w0,
  input  logic                       mbist_ce_r0,
  input  ram_access_pkg::ram_addr_t  wa,
  input  ram_access_pkg::ram_addr_t  ra,
  input  ram_access_pkg::ram_addr_t  mbist_wa_w0,
  input  ram_access_pkg::ram_addr_t  mbist_ra_r0,
  input  ram_access_pkg::ram_data_t  di,
  input  ram_access_pkg::mbist_pat_t mbist_di_w0,
  output ram_access_pkg::ram_data_t  dout,
  output ram_access_pkg::ram_data_t  mbist_do_r0
);

  logic                      arr_we;
  logic                      arr_re;
  ram_access_pkg::ram_addr_t arr_wa;
  ram_access_pkg::ram_addr_t arr_ra;
  ram_access_pkg::ram_data_t arr_wd;
  ram_access_pkg::ram_data_t arr_rd;
  ram_access_pkg::port_src_t port_src;
  ram_access_pkg::ram_data_t data_q;

  // ------------------------------------------------------------
  // port steering
  // ------------------------------------------------------------
  ram_port_mux u_port_mux (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .mbist_en_sync        (mbist_en_sync),
    .we                   (we),
    .re                   (re),
    .write_inh            (write_inh),
    .mbist_we_w0          (mbist_we_w0),
    .mbist_ce_r0          (mbist_ce_r0),
    .wa                   (wa),
    .ra                   (ra),
    .mbist_wa_w0          (mbist_wa_w0),
    .mbist_ra_r0          (mbist_ra_r0),
    .di                   (di),
    .mbist_di_w0          (mbist_di_w0),
    .arr_we               (arr_we),
    .arr_re               (arr_re),
    .arr_wa               (arr_wa),
    .arr_ra               (arr_ra),
    .arr_wd               (arr_wd),
    .port_src             (port_src)
  );

  ram_array_128x11 u_array (
    .clk    (clk),
    .arr_we (arr_we),
    .arr_re (arr_re),
    .arr_wa (arr_wa),
    .arr_ra (arr_ra),
    .arr_wd (arr_wd),
    .arr_rd (arr_rd)
  );

  // ------------------------------------------------------------
  // output capture
  // ------------------------------------------------------------
  ram_read_capture u_read_capture (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .ore                  (ore),
    .mbist_ce_r0          (mbist_ce_r0),
    .scan_ramtms          (scan_ramtms),
    .ary_read_inh         (ary_read_inh),
    .port_src             (port_src),
    .arr_rd               (arr_rd),
    .arr_wd               (arr_wd),
    .data_q               (data_q)
  );

  // one register serves both the functional and the MBIST read data
  assign dout        = data_q;
  assign mbist_do_r0 = data_q;

endmodule

// File: bench/tb_ram_access.sv
// testbench for the RAM access shell: replays the vector file one line per clock
// and checks dout and mbist_do_r0 against the expected columns of each line
`timescale 1ns/10ps

module tb_ram_access;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 4;
  localparam int num_vecs     = 53;
  localparam int vec_fields   = 18;
  localparam int timeout_ns   = (num_vecs + 20) * clk_period;

  // ------------------------------------------------------------
  // column offsets within one vector
  // ------------------------------------------------------------
  localparam int f_mbist_en   = 0;
  localparam int f_we         = 1;
  localparam int f_re         = 2;
  localparam int f_ore        = 3;
  localparam int f_write_inh  = 4;
  localparam int f_ramtms     = 5;
  localparam int f_read_inh   = 6;
  localparam int f_mbist_we   = 7;
  localparam int f_mbist_ce   = 8;
  localparam int f_wa         = 9;
  localparam int f_ra         = 10;
  localparam int f_mbist_wa   = 11;
  localparam int f_mbist_ra   = 12;
  localparam int f_di         = 13;
  localparam int f_mbist_pat  = 14;
  localparam int f_exp_dout   = 15;
  localparam int f_exp_mbist  = 16;
  localparam int f_chk        = 17;

  logic                       clk;
  logic                       mbist_ramaccess_rst_;
  logic                       we;
  logic                       re;
  logic                       ore;
  logic                       write_inh;
  logic                       scan_ramtms;
  logic                       ary_read_inh;
  logic                       mbist_en_sync;
  logic                       mbist_we_w0;
  logic                       mbist_ce_r0;
  ram_access_pkg::ram_addr_t  wa;
  ram_access_pkg::ram_addr_t  ra;
  ram_access_pkg::ram_addr_t  mbist_wa_w0;
  ram_access_pkg::ram_addr_t  mbist_ra_r0;
  ram_access_pkg::ram_data_t  di;
  ram_access_pkg::mbist_pat_t mbist_di_w0;
  ram_access_pkg::ram_data_t  dout;
  ram_access_pkg::ram_data_t  mbist_do_r0;

  // one 12-bit slot per column, vec_fields slots per vector
  logic [11:0] vec_mem [num_vecs * vec_fields];

  ram_access_top DUT (
    .clk                  (clk),
    .mbist_ramaccess_rst_ (mbist_ramaccess_rst_),
    .we                   (we),
    .re                   (re),
    .ore                  (ore),
    .write_inh            (write_inh),
    .scan_ramtms          (scan_ramtms),
    .ary_read_inh         (ary_read_inh),
    .mbist_en_sync        (mbist_en_sync),
    .mbist_we_w0          (mbist_we_w0),
    .mbist_ce_r0          (mbist_ce_r0),
    .wa                   (wa),
    .ra                   (ra),
    .mbist_wa_w0          (mbist_wa_w0),
    .mbist_ra_r0          (mbist_ra_r0),
    .di                   (di),
    .mbist_di_w0          (mbist_di_w0),
    .dout                 (dout),
    .mbist_do_r0          (mbist_do_r0)
  );

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic compare_value(input string name, input int idx,
                               input ram_access_pkg::ram_data_t actual,
                               input ram_access_pkg::ram_data_t expected);
    if (actual !== expected) begin
      $display("** Error: %s = 0x%03h, expected 0x%03h (vector %0d, %0t)",
               name, actual, expected, idx, $time);
      $display("=== FAIL ===");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic drive_vector(input int idx);
    int base;
    base = idx * vec_fields;
    mbist_en_sync <= vec_mem[base + f_mbist_en][0];
    we            <= vec_mem[base + f_we][0];
    re            <= vec_mem[base + f_re][0];
    ore           <= vec_mem[base + f_ore][0];
    write_inh     <= vec_mem[base + f_write_inh][0];
    scan_ramtms   <= vec_mem[base + f_ramtms][0];
    ary_read_inh  <= vec_mem[base + f_read_inh][0];
    mbist_we_w0   <= vec_mem[base + f_mbist_we][0];
    mbist_ce_r0   <= vec_mem[base + f_mbist_ce][0];
    wa            <= vec_mem[base + f_wa][6:0];
    ra            <= vec_mem[base + f_ra][6:0];
    mbist_wa_w0   <= vec_mem[base + f_mbist_wa][6:0];
    mbist_ra_r0   <= vec_mem[base + f_mbist_ra][6:0];
    di            <= vec_mem[base + f_di][10:0];
    mbist_di_w0   <= vec_mem[base + f_mbist_pat][1:0];
  endtask

  task automatic drive_idle();
    we            <= 1'b0;
    re            <= 1'b0;
    ore           <= 1'b0;
    write_inh     <= 1'b0;
    scan_ramtms   <= 1'b0;
    ary_read_inh  <= 1'b0;
    mbist_en_sync <= 1'b0;
    mbist_we_w0   <= 1'b0;
    mbist_ce_r0   <= 1'b0;
  endtask

  // outputs here reflect the vector sampled at the last rising edge
  task automatic check_vector(input int idx);
    int base;
    base = idx * vec_fields;
    if (vec_mem[base + f_chk][0]) begin
      compare_value("dout", idx, dout, vec_mem[base + f_exp_dout][10:0]);
      compare_value("mbist_do_r0", idx, mbist_do_r0, vec_mem[base + f_exp_mbist][10:0]);
    end
  endtask

  // ------------------------------------------------------------
  // clock and watchdog
  // ------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(timeout_ns);
    $display("timeout: the vectors did not finish within %0d ns", timeout_ns);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    mbist_ramaccess_rst_ = 1'b0;
    we            = 1'b0;
    re            = 1'b0;
    ore           = 1'b0;
    write_inh     = 1'b0;
    scan_ramtms   = 1'b0;
    ary_read_inh  = 1'b0;
    mbist_en_sync = 1'b0;
    mbist_we_w0   = 1'b0;
    mbist_ce_r0   = 1'b0;
    wa            = '0;
    ra            = '0;
    mbist_wa_w0   = '0;
    mbist_ra_r0   = '0;
    di            = '0;
    mbist_di_w0   = '0;

    // all ones marks slots the file did not fill
    for (int i = 0; i < num_vecs * vec_fields; i++) begin
      vec_mem[i] = '1;
    end
    $readmemh("bench/ram_access_golden.hex", vec_mem);
    if (vec_mem[(num_vecs - 1) * vec_fields + f_chk] > 12'h001) begin
      $display("the vector file is missing or holds fewer than %0d vectors", num_vecs);
      $display("=== FAIL ===");
      $fatal(1, "bad vector file");
    end

    repeat (reset_cycles) @(posedge clk);
    mbist_ramaccess_rst_ <= 1'b1;

    // one extra pass drives idle so the last vector can be checked
    for (int k = 0; k <= num_vecs; k++) begin
      @(posedge clk);
      if (k < num_vecs) begin
        drive_vector(k);
      end else begin
        drive_idle();
      end
      @(negedge clk);
      if (k > 0) begin
        check_vector(k - 1);
      end
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: bench/ram_access_golden.hex
// columns: mbist_en_sync we re ore write_inh scan_ramtms ary_read_inh mbist_we_w0 mbist_ce_r0
//          wa ra mbist_wa_w0 mbist_ra_r0 di mbist_di_w0 exp_dout exp_mbist_do_r0 check
// expected values are the capture register after the edge that samples the line
// idle after reset
0 0 0 0 0 0 0 0 0 00 00 00 00 000 0 000 000 1
// functional writes
0 1 0 0 0 0 0 0 0 05 00 00 00 123 0 000 000 1
0 1 0 0 0 0 0 0 0 12 00 00 00 456 0 000 000 1
0 1 0 0 0 0 0 0 0 7f 00 00 00 7ff 0 000 000 1
0 1 0 0 0 0 0 0 0 00 00 00 00 0a5 0 000 000 1
// read then capture with ore
0 0 1 0 0 0 0 0 0 00 05 00 00 000 0 000 000 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 123 123 1
0 0 1 0 0 0 0 0 0 00 12 00 00 000 0 123 123 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 456 456 1
0 0 1 0 0 0 0 0 0 00 7f 00 00 000 0 456 456 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 7ff 7ff 1
0 0 1 0 0 0 0 0 0 00 00 00 00 000 0 7ff 7ff 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 0a5 0a5 1
// read and write to word 05 at one edge, old word comes back
0 1 1 0 0 0 0 0 0 05 05 00 00 3c3 0 0a5 0a5 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 123 123 1
0 0 1 0 0 0 0 0 0 00 05 00 00 000 0 123 123 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 3c3 3c3 1
// back to back reads with ore overlapping
0 0 1 0 0 0 0 0 0 00 12 00 00 000 0 3c3 3c3 1
0 0 1 1 0 0 0 0 0 00 7f 00 00 000 0 456 456 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 7ff 7ff 1
// write inhibit
0 1 0 0 1 0 0 0 0 12 00 00 00 001 0 7ff 7ff 1
0 1 0 0 1 0 0 0 0 7f 00 00 00 002 0 7ff 7ff 1
0 0 1 0 0 0 0 0 0 00 12 00 00 000 0 7ff 7ff 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 456 456 1
0 0 1 0 0 0 0 0 0 00 7f 00 00 000 0 456 456 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 7ff 7ff 1
// array bypass
0 0 0 1 0 1 0 0 0 00 00 00 00 2b4 0 2b4 2b4 1
0 0 0 1 0 0 1 0 0 00 00 00 00 14b 0 14b 14b 1
0 0 0 1 0 1 1 0 0 00 00 00 00 06e 0 06e 06e 1
0 0 0 1 0 0 0 0 0 00 00 00 00 06e 0 7ff 7ff 1
0 0 0 0 0 1 0 0 0 00 00 00 00 555 0 7ff 7ff 1
// MBIST enable, pattern writes, functional write ignored
1 0 0 0 0 0 0 0 0 00 00 00 00 000 0 7ff 7ff 1
1 1 0 0 0 0 0 1 0 12 00 05 00 000 1 7ff 7ff 1
1 0 0 0 0 0 0 1 0 00 00 40 00 000 2 7ff 7ff 1
1 0 0 0 0 0 0 1 0 00 00 41 00 000 0 7ff 7ff 1
// MBIST reads, data one edge after the chip enable
1 0 0 1 0 0 0 0 1 00 00 00 05 000 0 7ff 7ff 1
1 0 0 0 0 0 0 0 0 00 00 00 00 000 0 555 555 1
1 0 0 0 0 0 0 0 1 00 00 00 40 000 0 555 555 1
1 0 0 1 0 0 0 0 0 00 00 00 00 000 0 2aa 2aa 1
1 0 0 0 0 0 0 0 1 00 00 00 41 000 0 2aa 2aa 1
1 0 0 0 0 0 0 0 0 00 00 00 00 000 0 000 000 1
1 0 0 0 0 0 0 0 1 00 00 00 05 000 0 000 000 1
1 0 0 0 0 0 0 0 1 00 00 00 40 000 0 555 555 1
1 0 0 0 0 0 0 0 1 00 00 00 41 000 0 2aa 2aa 1
1 0 0 0 0 0 0 0 0 00 00 00 00 000 0 000 000 1
// ore with bypass has no effect in MBIST mode
1 0 0 1 0 1 0 0 0 00 00 00 00 000 1 000 000 1
// back to functional side
0 0 0 0 0 0 0 0 0 00 00 00 00 000 0 000 000 1
0 0 1 0 0 0 0 0 0 00 12 00 00 000 0 000 000 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 456 456 1
0 0 1 0 0 0 0 0 0 00 05 00 00 000 0 456 456 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 555 555 1
0 0 1 0 0 0 0 0 0 00 40 00 00 000 0 555 555 1
0 0 0 1 0 0 0 0 0 00 00 00 00 000 0 2aa 2aa 1

// File: filelist.f
hdl/ram_access_pkg.sv
hdl/ram_port_mux.sv
hdl/ram_array_128x11.sv
hdl/ram_read_capture.sv
hdl/ram_access_top.sv
bench/tb_ram_access.sv

// File: run_sim.sh
#!/bin/sh
# build the RAM access testbench with Verilator, run it into sim.log
# and decide pass or fail from the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_ram_access -f filelist.f \
  && ./obj_dir/Vtb_ram_access > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "=== PASS ===" sim.log 2>/dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
